//--- dz_pkg.sv
package dz_pkg;

    // glyph index into the bitmap table
    typedef enum logic [3:0] {
        G_LVL0  = 4'd0,
        G_LVL1  = 4'd1,
        G_LVL2  = 4'd2,
        G_LVL3  = 4'd3,
        G_LVL4  = 4'd4,
        G_LVL5  = 4'd5,
        G_FAN   = 4'd6,
        G_DROP  = 4'd7,
        G_WARN  = 4'd8,
        G_BLANK = 4'd9
    } glyph_e;

    typedef enum logic {
        MODE_LEVEL = 1'b0,  // fill level from temperature
        MODE_ICON  = 1'b1   // fixed icon from the icon input
    } mode_e;

    // request into the display block, sampled once per frame
    typedef struct packed {
        glyph_e glyph;
        logic   alarm;
    } disp_req_t;

    typedef struct packed {
        logic [2:0] row_idx;
        logic       frame_start;    // one cycle, row_idx just wrapped to 0
    } scan_t;

    // rising thresholds, index 0 is the lowest
    localparam logic [4:0][7:0] LEVEL_THRESH = {8'd200, 8'd160, 8'd120, 8'd80, 8'd40};

    // level only drops once the code is this far under its threshold
    localparam logic [7:0] LEVEL_HYST = 8'd8;

    localparam logic [2:0] ALARM_LEVEL = 3'd5;

endpackage

//--- heat_level.sv
`timescale 1ns/100ps

module heat_level (
    input  logic       clk,
    input  logic       rst,
    input  logic       sample,
    input  logic [7:0] temp_code,
    output logic [2:0] level,
    output logic       alarm
);

    logic [2:0] up_cnt;
    logic [2:0] level_nxt;
    logic [7:0] fall_lim;

    // count of thresholds met by the current code
    always_comb
    begin
        up_cnt = 3'd0;
        for (int i = 0; i < 5; i++)
        begin
            if (temp_code >= dz_pkg::LEVEL_THRESH[i])
                up_cnt = up_cnt + 3'd1;
        end
    end

    always_comb
    begin
        fall_lim = 8'd0;
        if (level != 3'd0)
            fall_lim = dz_pkg::LEVEL_THRESH[level - 3'd1] - dz_pkg::LEVEL_HYST;
    end

    // rise straight to the new count, fall one step per sample
    always_comb
    begin
        level_nxt = level;
        if (up_cnt > level)
            level_nxt = up_cnt;
        else if (level != 3'd0 && temp_code < fall_lim)
            level_nxt = level - 3'd1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            level <= 3'd0;
            alarm <= 1'b0;
        end
        else if (sample)
        begin
            level <= level_nxt;
            alarm <= (level_nxt == dz_pkg::ALARM_LEVEL);
        end
    end

    a_level_range: assert property (@(posedge clk) disable iff (rst) level <= 3'd5)
        else $error("heat_level: level out of range");

endmodule

//--- row_scanner.sv
`timescale 1ns/100ps

module row_scanner #(
    parameter int SCAN_DIV = 4
) (
    input  logic          clk,
    input  logic          rst,
    output dz_pkg::scan_t scan
);

    // at least one bit so SCAN_DIV of 1 still builds
    localparam int CW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CW-1:0] pre_cnt;
    logic          step;

    assign step = (pre_cnt == CW'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre_cnt          <= '0;
            scan.row_idx     <= 3'd0;
            scan.frame_start <= 1'b0;
        end
        else
        begin
            scan.frame_start <= step && (scan.row_idx == 3'd7);    // wrap to row 0
            if (step)
            begin
                pre_cnt      <= '0;
                scan.row_idx <= scan.row_idx + 3'd1;
            end
            else
                pre_cnt <= pre_cnt + 1'b1;
        end
    end

    a_frame_on_row0: assert property (@(posedge clk) disable iff (rst)
        scan.frame_start |-> scan.row_idx == 3'd0)
        else $error("row_scanner: frame_start away from row 0");

endmodule

//--- glyph_rom.sv
`timescale 1ns/100ps

module glyph_rom (
    input  dz_pkg::glyph_e glyph,
    input  logic [2:0]     row_idx,
    output logic [7:0]     cols
);

    always_comb
    begin
        cols = 8'b0000_0000;
        case (glyph)
            dz_pkg::G_LVL0:
            begin
                if (row_idx == 3'd3 || row_idx == 3'd4)
                    cols = 8'b0001_1000;
            end
            dz_pkg::G_LVL1:
            begin
                case (row_idx)
                    3'd2, 3'd5: cols = 8'b0001_1000;
                    3'd3, 3'd4: cols = 8'b0011_1100;
                    default:    cols = 8'b0000_0000;
                endcase
            end
            dz_pkg::G_LVL2:
            begin
                case (row_idx)
                    3'd2, 3'd5: cols = 8'b0011_1100;
                    3'd3, 3'd4: cols = 8'b0111_1110;
                    default:    cols = 8'b0000_0000;
                endcase
            end
            dz_pkg::G_LVL3:
            begin
                case (row_idx)
                    3'd1, 3'd6:             cols = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: cols = 8'b0111_1110;
                    default:                cols = 8'b0000_0000;
                endcase
            end
            dz_pkg::G_LVL4:
            begin
                case (row_idx)
                    3'd0, 3'd7: cols = 8'b0011_1100;
                    3'd1, 3'd6: cols = 8'b0111_1110;
                    default:    cols = 8'b1111_1111;
                endcase
            end
            dz_pkg::G_LVL5: cols = 8'b1111_1111;    // full panel
            dz_pkg::G_FAN:
            begin
                case (row_idx)
                    3'd0: cols = 8'b0110_0000;
                    3'd1: cols = 8'b0111_0000;
                    3'd2: cols = 8'b0011_0011;
                    3'd3: cols = 8'b0001_1111;
                    3'd4: cols = 8'b1111_1000;
                    3'd5: cols = 8'b1100_1100;
                    3'd6: cols = 8'b0000_1110;
                    3'd7: cols = 8'b0000_0110;
                endcase
            end
            dz_pkg::G_DROP:
            begin
                case (row_idx)
                    3'd0: cols = 8'b0001_1000;
                    3'd1: cols = 8'b0001_1000;
                    3'd2: cols = 8'b0011_1100;
                    3'd3: cols = 8'b0011_1100;
                    3'd4: cols = 8'b0111_1110;
                    3'd5: cols = 8'b0111_1010;  // highlight
                    3'd6: cols = 8'b0111_0110;
                    3'd7: cols = 8'b0011_1100;
                endcase
            end
            dz_pkg::G_WARN:
            begin
                // triangle with a bang
                case (row_idx)
                    3'd0: cols = 8'b0001_1000;
                    3'd1: cols = 8'b0010_0100;
                    3'd2: cols = 8'b0101_1010;
                    3'd3: cols = 8'b0101_1010;
                    3'd4: cols = 8'b1001_1001;
                    3'd5: cols = 8'b1000_0001;
                    3'd6: cols = 8'b1001_1001;
                    3'd7: cols = 8'b1111_1111;
                endcase
            end
            default: cols = 8'b0000_0000;   // blank and unused codes
        endcase
    end

endmodule

//--- dz_show.sv
`timescale 1ns/100ps

module dz_show (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  dz_pkg::disp_req_t req,
    input  dz_pkg::scan_t     scan,
    output logic [7:0]        row,
    output logic [7:0]        colg,
    output logic [7:0]        colr
);

    dz_pkg::disp_req_t shown_q;
    dz_pkg::disp_req_t cur;
    logic [7:0]        rom_cols;

    // new request takes effect on row 0 of its frame
    assign cur = scan.frame_start ? req : shown_q;

    glyph_rom glyph_rom_i (
        .glyph   (cur.glyph),
        .row_idx (scan.row_idx),
        .cols    (rom_cols)
    );

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shown_q <= '{glyph: dz_pkg::G_BLANK, alarm: 1'b0};
            row     <= 8'hff;
            colg    <= 8'h00;
            colr    <= 8'h00;
        end
        else
        begin
            if (scan.frame_start)
                shown_q <= req;
            row  <= ~(8'd1 << scan.row_idx);    // one active-low line
            colg <= st ? rom_cols : 8'h00;
            // red on top of green makes the alarm color
            colr <= (st && cur.alarm) ? rom_cols : 8'h00;
        end
    end

    a_one_row: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(~row))
        else $error("dz_show: row lines not one-hot low");

endmodule

//--- dz_top.sv
`timescale 1ns/100ps

module dz_top #(
    parameter int SCAN_DIV = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           st,
    input  logic           sample,
    input  logic [7:0]     temp_code,
    input  dz_pkg::mode_e  mode,
    input  dz_pkg::glyph_e icon,
    output logic [7:0]     row,
    output logic [7:0]     colg,
    output logic [7:0]     colr,
    output logic           alarm
);

    logic [2:0]        level;
    dz_pkg::scan_t     scan;
    dz_pkg::disp_req_t req;

    heat_level heat_level_i (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .temp_code (temp_code),
        .level     (level),
        .alarm     (alarm)
    );

    row_scanner #(.SCAN_DIV(SCAN_DIV)) row_scanner_i (
        .clk  (clk),
        .rst  (rst),
        .scan (scan)
    );

    // level glyphs sit at codes 0..5
    assign req.glyph = (mode == dz_pkg::MODE_ICON) ? icon : dz_pkg::glyph_e'({1'b0, level});
    assign req.alarm = alarm;

    dz_show dz_show_i (.clk(clk), .rst(rst), .st(st), .req(req), .scan(scan),
                       .row(row), .colg(colg), .colr(colr));

endmodule

//--- tb_dz_top.sv
`timescale 1ns/100ps

module tb_dz_top;

    localparam int SCAN_DIV  = 3;
    localparam int FRAME_TMO = 64 * SCAN_DIV;
    localparam logic [7:0] HYST_CODES [6] = '{8'd130, 8'd115, 8'd111, 8'd60, 8'd35, 8'd30};

    logic              clk;
    logic              rst;
    logic              st;
    logic              sample;
    logic [7:0]        temp_code;
    dz_pkg::mode_e     mode;
    dz_pkg::glyph_e    icon;
    logic [7:0]        row;
    logic [7:0]        colg;
    logic [7:0]        colr;
    logic              alarm;

    // reference state kept by the compare process
    logic [2:0]        lvl_m;
    logic              alarm_m;
    dz_pkg::disp_req_t req_d;
    dz_pkg::disp_req_t shown;
    logic              st_d;
    logic [7:0]        prev_row;
    logic [7:0]        exp_cols;
    logic [7:0]        cols_acc [8];
    int                cur_r;
    int                frame_cnt;

    string             test_name;
    logic [31:0]       rnd;
    logic [2:0]        exp_lvl;

    dz_top #(.SCAN_DIV(SCAN_DIV)) dz_top_i (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .sample    (sample),
        .temp_code (temp_code),
        .mode      (mode),
        .icon      (icon),
        .row       (row),
        .colg      (colg),
        .colr      (colr),
        .alarm     (alarm)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] ref_glyph(input dz_pkg::glyph_e g, input int r);
        logic [63:0] pat;   // row 0 in the top byte
        case (g)
            dz_pkg::G_LVL0: pat = 64'h0000_0018_1800_0000;
            dz_pkg::G_LVL1: pat = 64'h0000_183c_3c18_0000;
            dz_pkg::G_LVL2: pat = 64'h0000_3c7e_7e3c_0000;
            dz_pkg::G_LVL3: pat = 64'h003c_7e7e_7e7e_3c00;
            dz_pkg::G_LVL4: pat = 64'h3c7e_ffff_ffff_7e3c;
            dz_pkg::G_LVL5: pat = 64'hffff_ffff_ffff_ffff;
            dz_pkg::G_FAN:  pat = 64'h6070_331f_f8cc_0e06;
            dz_pkg::G_DROP: pat = 64'h1818_3c3c_7e7a_763c;
            dz_pkg::G_WARN: pat = 64'h1824_5a5a_9981_99ff;
            default:        pat = 64'h0;
        endcase
        return pat[63 - 8 * r -: 8];
    endfunction

    // jump up to the thresholds met, drop one step once below threshold minus margin
    function automatic logic [2:0] ref_level(input logic [2:0] prev, input logic [7:0] code);
        logic [2:0] met;
        met = 3'd0;
        for (int i = 0; i < 5; i++)
            if (code >= dz_pkg::LEVEL_THRESH[i])
                met = met + 3'd1;
        if (met > prev)
            return met;
        if (prev != 3'd0 && code < dz_pkg::LEVEL_THRESH[prev - 3'd1] - dz_pkg::LEVEL_HYST)
            return prev - 3'd1;
        return prev;
    endfunction

    // which level glyph the last full frame showed, 7 if none
    function automatic logic [2:0] decode_level();
        logic [2:0] found;
        logic       same;
        found = 3'd7;
        for (int lv = 0; lv < 6; lv++)
        begin
            same = 1'b1;
            for (int r = 0; r < 8; r++)
                if (cols_acc[r] != ref_glyph(dz_pkg::glyph_e'(4'(lv)), r))
                    same = 1'b0;
            if (same)
                found = 3'(lv);
        end
        return found;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_cols(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_on_error($sformatf("ERROR %s: expected %02h, actual %02h", name, exp, act));
    endtask

    task automatic check_level(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp)
            stop_on_error($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_alarm(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("ERROR %s: expected %0b, actual %0b", name, exp, act));
    endtask

    // returns once n new frames began and row 7 of the last one is on screen
    task automatic wait_frames(input int n);
        int start;
        int cnt;
        start = frame_cnt;
        cnt = 0;
        while (!(frame_cnt - start >= n && cur_r == 7))
        begin
            @(negedge clk);
            cnt++;
            if (cnt > n * FRAME_TMO)
                stop_on_error($sformatf("%s: no frame start seen before the timeout", test_name));
        end
    endtask

    task automatic apply_code(input logic [7:0] code);
        @(posedge clk);
        temp_code <= code;
        sample    <= 1'b1;
        exp_lvl = ref_level(exp_lvl, code);
        @(posedge clk);
        sample <= 1'b0;
    endtask

    task automatic check_shown_level();
        wait_frames(2);
        check_level({test_name, " level"}, exp_lvl, decode_level());
    endtask

    // outputs seen here were registered on the previous edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            lvl_m     = 3'd0;
            alarm_m   = 1'b0;
            req_d     = '{glyph: dz_pkg::G_BLANK, alarm: 1'b0};
            shown     = '{glyph: dz_pkg::G_BLANK, alarm: 1'b0};
            st_d      = 1'b0;
            prev_row  = 8'hff;
            cur_r     = 7;
            frame_cnt = 0;
        end
        else
        begin
            check_alarm({test_name, " alarm"}, alarm_m, alarm);
            if (row != prev_row)
            begin
                cur_r = (prev_row == 8'hff) ? 0 : (cur_r + 1) % 8;
                check_cols({test_name, " row"}, ~(8'd1 << cur_r), row);
                if (cur_r == 0 && prev_row == 8'h7f)
                begin
                    shown = req_d;  // request from the frame_start edge
                    frame_cnt++;
                end
            end
            exp_cols = (row == 8'hff) ? 8'h00 : ref_glyph(shown.glyph, cur_r);
            check_cols({test_name, " colg"}, st_d ? exp_cols : 8'h00, colg);
            check_cols({test_name, " colr"}, (st_d && shown.alarm) ? exp_cols : 8'h00, colr);
            cols_acc[cur_r] = colg;
            prev_row = row;
            st_d  = st;
            req_d = '{glyph: (mode == dz_pkg::MODE_ICON) ? icon : dz_pkg::glyph_e'({1'b0, lvl_m}),
                      alarm: alarm_m};
            if (sample)
            begin
                lvl_m   = ref_level(lvl_m, temp_code);
                alarm_m = (lvl_m == dz_pkg::ALARM_LEVEL);
            end
        end
    end

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        st        = 1'b0;
        sample    = 1'b0;
        temp_code = 8'h00;
        mode      = dz_pkg::MODE_LEVEL;
        icon      = dz_pkg::G_BLANK;
        rnd       = 32'he99a_6c40;
        exp_lvl   = 3'd0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        check_cols("reset row", 8'hff, row);
        check_cols("reset colg", 8'h00, colg);
        check_cols("reset colr", 8'h00, colr);
        check_alarm("reset alarm", 1'b0, alarm);
        rst <= 1'b0;
        st  <= 1'b1;

        test_name = "scan";
        wait_frames(1);     // row order and blank glyph checked on the fly

        test_name = "icons";
        for (int i = 0; i < 3; i++)
        begin
            @(posedge clk);
            mode <= dz_pkg::MODE_ICON;
            icon <= dz_pkg::glyph_e'(4'(6 + i));
            wait_frames(3);
        end

        test_name = "levels";
        @(posedge clk);
        mode <= dz_pkg::MODE_LEVEL;
        for (int i = 0; i < 6; i++)
        begin
            apply_code(HYST_CODES[i]);
            check_shown_level();
        end
        for (int i = 0; i < 16; i++)
        begin
            rnd = xorshift32(rnd);
            apply_code(rnd[7:0]);
            check_shown_level();
        end

        test_name = "alarm";
        apply_code(8'd210);
        @(negedge clk);
        check_alarm("alarm rise", 1'b1, alarm);
        check_shown_level();
        apply_code(8'd185);
        @(negedge clk);
        check_alarm("alarm clear", 1'b0, alarm);
        check_shown_level();

        test_name = "blank";
        @(posedge clk);
        st <= 1'b0;
        wait_frames(1);
        check_cols("blank colg", 8'h00, colg);
        @(posedge clk);
        st <= 1'b1;
        check_shown_level();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- dz_top.f
dz_pkg.sv
heat_level.sv
row_scanner.sv
glyph_rom.sv
dz_show.sv
dz_top.sv
tb_dz_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_dz_top
FILELIST  := dz_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
